/* hw/la32_isa_pkg.sv */
package la32_isa_pkg;

    localparam int NUM_REGS = 32;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [29:0] waddr_t;

    localparam word_t RESET_PC = 32'h1c00_0000;

    // add.w, sub.w, and, or, xor
    typedef struct packed {
        logic [5:0] op_hi;
        logic [3:0] op_mid;
        logic [6:0] op_lo;
        reg_addr_t  rk;
        reg_addr_t  rj;
        reg_addr_t  rd;
    } fmt_3r_t;

    // addi.w, ld.w, st.w
    typedef struct packed {
        logic [9:0]  op;
        logic [11:0] si12;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_2ri12_t;

    // lu12i.w
    typedef struct packed {
        logic [6:0]  op;
        logic [19:0] si20;
        reg_addr_t   rd;
    } fmt_1ri20_t;

    // beq, bne
    typedef struct packed {
        logic [5:0]  op;
        logic [15:0] offs16;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_2ri16_t;

    // b, offset is split with the high part at the bottom
    typedef struct packed {
        logic [5:0]  op;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fmt_i26_t;

    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
        fmt_1ri20_t ri20;
        fmt_2ri16_t ri16;
        fmt_i26_t   i26;
    } inst_t;

    // major opcodes, bits 31:26
    localparam logic [5:0] OP6_ARITH   = 6'h00;
    localparam logic [5:0] OP6_LU12I_W = 6'h05;
    localparam logic [5:0] OP6_MEM     = 6'h0a;
    localparam logic [5:0] OP6_B       = 6'h14;
    localparam logic [5:0] OP6_BEQ     = 6'h16;
    localparam logic [5:0] OP6_BNE     = 6'h17;

    // bits 25:22 under OP6_ARITH or OP6_MEM
    localparam logic [3:0] OP4_ADDI_W  = 4'ha;
    localparam logic [3:0] OP4_LD_W    = 4'h2;
    localparam logic [3:0] OP4_ST_W    = 4'h6;

    // full 17-bit opcodes of the register forms
    localparam logic [16:0] OP17_ADD_W = 17'h00020;
    localparam logic [16:0] OP17_SUB_W = 17'h00022;
    localparam logic [16:0] OP17_AND   = 17'h00029;
    localparam logic [16:0] OP17_OR    = 17'h0002a;
    localparam logic [16:0] OP17_XOR   = 17'h0002b;

endpackage

/* hw/pipe_pkg.sv */
package pipe_pkg;

    import la32_isa_pkg::*;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_ALWAYS
    } br_kind_t;

    typedef struct packed {
        alu_op_t  alu_op;
        logic     src2_imm;
        logic     mem_we;
        logic     rf_we;
        logic     wb_load;
        br_kind_t br_kind;
    } ctrl_t;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_t;

    typedef struct packed {
        word_t     pc;
        ctrl_t     ctrl;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        logic      use_r1;
        logic      use_r2;
        word_t     rdata1;
        word_t     rdata2;
        word_t     imm;
        word_t     br_offs;
        reg_addr_t dest;
    } id_ex_t;

    typedef struct packed {
        word_t     pc;
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        logic      wb_load;
        word_t     alu_result;
        word_t     load_data;
        reg_addr_t dest;
    } mem_wb_t;

endpackage

/* hw/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder import la32_isa_pkg::*; import pipe_pkg::*; (
    input  inst_t     inst,
    output ctrl_t     ctrl,
    output reg_addr_t raddr1,
    output reg_addr_t raddr2,
    output logic      use_r1,
    output logic      use_r2,
    output reg_addr_t dest,
    output word_t     imm,
    output word_t     br_offs
);

    logic [16:0] op17;
    logic        is_3r;
    logic        is_b;
    logic        rd_is_src;

    assign op17 = {inst.r3.op_hi, inst.r3.op_mid, inst.r3.op_lo};

    always_comb begin
        ctrl      = '0;
        use_r1    = 1'b0;
        use_r2    = 1'b0;
        rd_is_src = 1'b0;
        is_b      = 1'b0;
        is_3r     = 1'b1;
        case (op17)
            OP17_ADD_W: ctrl.alu_op = ALU_ADD;
            OP17_SUB_W: ctrl.alu_op = ALU_SUB;
            OP17_AND:   ctrl.alu_op = ALU_AND;
            OP17_OR:    ctrl.alu_op = ALU_OR;
            OP17_XOR:   ctrl.alu_op = ALU_XOR;
            default:    is_3r = 1'b0;
        endcase
        if (is_3r) begin
            ctrl.rf_we = 1'b1;
            use_r1     = 1'b1;
            use_r2     = 1'b1;
        end else if (inst.ri12.op == {OP6_ARITH, OP4_ADDI_W}) begin
            ctrl.src2_imm = 1'b1;
            ctrl.rf_we    = 1'b1;
            use_r1        = 1'b1;
        end else if (inst.ri12.op == {OP6_MEM, OP4_LD_W}) begin
            ctrl.src2_imm = 1'b1;
            ctrl.rf_we    = 1'b1;
            ctrl.wb_load  = 1'b1;
            use_r1        = 1'b1;
        end else if (inst.ri12.op == {OP6_MEM, OP4_ST_W}) begin
            ctrl.src2_imm = 1'b1;
            ctrl.mem_we   = 1'b1;
            use_r1        = 1'b1;
            use_r2        = 1'b1;
            rd_is_src     = 1'b1;
        end else if (inst.ri20.op == {OP6_LU12I_W, 1'b0}) begin
            ctrl.alu_op   = ALU_LUI;
            ctrl.src2_imm = 1'b1;
            ctrl.rf_we    = 1'b1;
        end else if (inst.ri16.op == OP6_BEQ || inst.ri16.op == OP6_BNE) begin
            ctrl.br_kind = (inst.ri16.op == OP6_BEQ) ? BR_BEQ : BR_BNE;
            use_r1       = 1'b1;
            use_r2       = 1'b1;
            rd_is_src    = 1'b1;
        end else if (inst.i26.op == OP6_B) begin
            ctrl.br_kind = BR_ALWAYS;
            is_b         = 1'b1;
        end
    end

    assign raddr1 = inst.r3.rj;
    // stores and branches read rd as their second source
    assign raddr2 = rd_is_src ? inst.r3.rd : inst.r3.rk;
    assign dest   = inst.r3.rd;

    assign imm = (ctrl.alu_op == ALU_LUI) ? {inst.ri20.si20, 12'b0}
                                          : {{20{inst.ri12.si12[11]}}, inst.ri12.si12};

    assign br_offs = is_b ? {{4{inst.i26.offs_hi[9]}}, inst.i26.offs_hi, inst.i26.offs_lo, 2'b00}
                          : {{14{inst.ri16.offs16[15]}}, inst.ri16.offs16, 2'b00};

endmodule

/* hw/regfile.sv */
`timescale 1ns/10ps

module regfile import la32_isa_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [NUM_REGS];
    logic  wr_live;

    assign wr_live = we && (waddr != '0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so decode sees the value being written back
    assign rdata1 = (wr_live && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (wr_live && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

/* hw/hazard_unit.sv */
`timescale 1ns/10ps

module hazard_unit import la32_isa_pkg::*; import pipe_pkg::*; (
    input  id_ex_t   id_ex,
    input  ex_mem_t  ex_mem,
    input  mem_wb_t  mem_wb,
    input  logic     branch_taken,
    output fwd_sel_t fwd1_sel,
    output fwd_sel_t fwd2_sel,
    output logic     stall,
    output logic     flush
);

    logic ex_writes;
    logic wb_writes;
    logic ex_hit1;
    logic ex_hit2;
    logic wb_hit1;
    logic wb_hit2;
    logic load_use;

    // r0 results are never forwarded
    assign ex_writes = ex_mem.ctrl.rf_we && (ex_mem.dest != '0);
    assign wb_writes = mem_wb.rf_we && (mem_wb.dest != '0);

    assign ex_hit1 = id_ex.use_r1 && ex_writes && (ex_mem.dest == id_ex.raddr1);
    assign ex_hit2 = id_ex.use_r2 && ex_writes && (ex_mem.dest == id_ex.raddr2);
    assign wb_hit1 = id_ex.use_r1 && wb_writes && (mem_wb.dest == id_ex.raddr1);
    assign wb_hit2 = id_ex.use_r2 && wb_writes && (mem_wb.dest == id_ex.raddr2);

    // load data only exists from MEM/WB onward
    assign load_use = ex_mem.ctrl.wb_load && (ex_hit1 || ex_hit2);

    assign fwd1_sel = (ex_hit1 && !ex_mem.ctrl.wb_load) ? FWD_EX_MEM :
                      wb_hit1                           ? FWD_MEM_WB : FWD_RF;
    assign fwd2_sel = (ex_hit2 && !ex_mem.ctrl.wb_load) ? FWD_EX_MEM :
                      wb_hit2                           ? FWD_MEM_WB : FWD_RF;

    assign stall = load_use;
    // a branch waiting on a load compares stale operands, so it decides next cycle
    assign flush = branch_taken && !load_use;

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage import la32_isa_pkg::*; import pipe_pkg::*; (
    input  id_ex_t   id_ex,
    input  fwd_sel_t fwd1_sel,
    input  fwd_sel_t fwd2_sel,
    input  word_t    ex_mem_result,
    input  word_t    wb_value,
    output word_t    alu_result,
    output word_t    store_data,
    output logic     branch_taken,
    output word_t    branch_target
);

    word_t op1;
    word_t op2;
    word_t src2;
    logic  ops_equal;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf_val,
                                      input word_t exm_val, input word_t wb_val);
        case (sel)
            FWD_EX_MEM: return exm_val;
            FWD_MEM_WB: return wb_val;
            default:    return rf_val;
        endcase
    endfunction

    assign op1  = fwd_mux(fwd1_sel, id_ex.rdata1, ex_mem_result, wb_value);
    assign op2  = fwd_mux(fwd2_sel, id_ex.rdata2, ex_mem_result, wb_value);
    assign src2 = id_ex.ctrl.src2_imm ? id_ex.imm : op2;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_result = op1 - src2;
            ALU_AND: alu_result = op1 & src2;
            ALU_OR:  alu_result = op1 | src2;
            ALU_XOR: alu_result = op1 ^ src2;
            ALU_LUI: alu_result = id_ex.imm;
            default: alu_result = op1 + src2;
        endcase
    end

    assign store_data = op2;

    assign ops_equal     = (op1 == op2);
    assign branch_taken  = (id_ex.ctrl.br_kind == BR_BEQ && ops_equal)
                        || (id_ex.ctrl.br_kind == BR_BNE && !ops_equal)
                        || (id_ex.ctrl.br_kind == BR_ALWAYS);
    assign branch_target = id_ex.pc + id_ex.br_offs;

endmodule

/* hw/la32_core.sv */
`timescale 1ns/10ps

module la32_core import la32_isa_pkg::*; import pipe_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    output waddr_t    imem_addr,
    input  word_t     imem_rdata,
    output logic      dmem_we,
    output waddr_t    dmem_addr,
    output word_t     dmem_wdata,
    input  word_t     dmem_rdata,
    output word_t     wb_pc,
    output logic      wb_we,
    output reg_addr_t wb_dest,
    output word_t     wb_data
);

    word_t    pc;
    inst_t    if_id_inst;
    word_t    if_id_pc;
    id_ex_t   id_ex;
    id_ex_t   id_next;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    word_t    rf_rdata1;
    word_t    rf_rdata2;
    word_t    alu_result;
    word_t    store_data;
    logic     branch_taken;
    word_t    branch_target;
    fwd_sel_t fwd1_sel;
    fwd_sel_t fwd2_sel;
    logic     stall;
    logic     flush;
    word_t    wb_value;

    assign imem_addr = pc[31:2];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= RESET_PC;
        end else if (flush) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    // cleared word decodes as a no-op
    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            if_id_inst <= '0;
            if_id_pc   <= '0;
        end else if (!stall) begin
            if_id_inst <= imem_rdata;
            if_id_pc   <= pc;
        end
    end

    inst_decoder u_decoder (
        .inst    (if_id_inst),
        .ctrl    (id_next.ctrl),
        .raddr1  (id_next.raddr1),
        .raddr2  (id_next.raddr2),
        .use_r1  (id_next.use_r1),
        .use_r2  (id_next.use_r2),
        .dest    (id_next.dest),
        .imm     (id_next.imm),
        .br_offs (id_next.br_offs)
    );

    regfile u_regfile (
        .clk    (clk),
        .rstn   (rstn),
        .raddr1 (id_next.raddr1),
        .raddr2 (id_next.raddr2),
        .we     (wb_we),
        .waddr  (mem_wb.dest),
        .wdata  (wb_value),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    assign id_next.pc     = if_id_pc;
    assign id_next.rdata1 = rf_rdata1;
    assign id_next.rdata2 = rf_rdata2;

    // on a load-use stall the consumer waits here
    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            id_ex <= '0;
        end else if (!stall) begin
            id_ex <= id_next;
        end else begin
            // the MEM/WB producer retires while the consumer waits
            if (fwd1_sel == FWD_MEM_WB) begin
                id_ex.rdata1 <= wb_value;
            end
            if (fwd2_sel == FWD_MEM_WB) begin
                id_ex.rdata2 <= wb_value;
            end
        end
    end

    hazard_unit u_hazard (
        .id_ex        (id_ex),
        .ex_mem       (ex_mem),
        .mem_wb       (mem_wb),
        .branch_taken (branch_taken),
        .fwd1_sel     (fwd1_sel),
        .fwd2_sel     (fwd2_sel),
        .stall        (stall),
        .flush        (flush)
    );

    execute_stage u_execute (
        .id_ex         (id_ex),
        .fwd1_sel      (fwd1_sel),
        .fwd2_sel      (fwd2_sel),
        .ex_mem_result (ex_mem.alu_result),
        .wb_value      (wb_value),
        .alu_result    (alu_result),
        .store_data    (store_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    // bubble goes in behind the held instruction
    always_ff @(posedge clk) begin
        if (!rstn || stall) begin
            ex_mem <= '0;
        end else begin
            ex_mem.pc         <= id_ex.pc;
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= store_data;
            ex_mem.dest       <= id_ex.dest;
        end
    end

    assign dmem_we    = ex_mem.ctrl.mem_we;
    assign dmem_addr  = ex_mem.alu_result[31:2];
    assign dmem_wdata = ex_mem.store_data;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_wb <= '0;
        end else begin
            mem_wb.pc         <= ex_mem.pc;
            mem_wb.rf_we      <= ex_mem.ctrl.rf_we;
            mem_wb.wb_load    <= ex_mem.ctrl.wb_load;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= dmem_rdata;
            mem_wb.dest       <= ex_mem.dest;
        end
    end

    assign wb_value = mem_wb.wb_load ? mem_wb.load_data : mem_wb.alu_result;

    // writes to r0 do not count as commits
    assign wb_pc   = mem_wb.pc;
    assign wb_we   = mem_wb.rf_we && (mem_wb.dest != '0);
    assign wb_dest = mem_wb.dest;
    assign wb_data = wb_value;

endmodule

/* sim/la32_asserts.sv */
`timescale 1ns/10ps

module la32_asserts import pipe_pkg::*; (
    input logic     clk,
    input logic     rstn,
    input logic     wb_we,
    input logic     stall,
    input logic     flush,
    input fwd_sel_t fwd1_sel,
    input fwd_sel_t fwd2_sel,
    input ex_mem_t  ex_mem,
    input mem_wb_t  mem_wb,
    input logic     dmem_we
);

    int fail_count = 0;

    // the first reset edge clears mem_wb, so check from the second one on
    a_no_commit_in_reset: assert property (@(posedge clk) (!rstn && $past(!rstn)) |-> !wb_we)
        else begin
            $error("commit while in reset");
            fail_count++;
        end

    // a stall leaves a bubble in EX/MEM and a flush one in ID/EX
    a_no_repeat_stall: assert property (@(posedge clk) disable iff (!rstn)
        (stall || flush) |=> !stall)
        else begin
            $error("stall raised right after a stall or flush");
            fail_count++;
        end

    a_fwd_ex_mem_r0: assert property (@(posedge clk) disable iff (!rstn)
        (fwd1_sel == FWD_EX_MEM || fwd2_sel == FWD_EX_MEM) |-> ex_mem.dest != '0)
        else begin
            $error("forward from EX/MEM with r0 destination");
            fail_count++;
        end

    a_fwd_mem_wb_r0: assert property (@(posedge clk) disable iff (!rstn)
        (fwd1_sel == FWD_MEM_WB || fwd2_sel == FWD_MEM_WB) |-> mem_wb.dest != '0)
        else begin
            $error("forward from MEM/WB with r0 destination");
            fail_count++;
        end

    // only a decoded st.w may drive the data write
    a_store_in_mem: assert property (@(posedge clk) disable iff (!rstn)
        dmem_we |-> (ex_mem.ctrl.alu_op == ALU_ADD && ex_mem.ctrl.src2_imm
                     && !ex_mem.ctrl.rf_we && !ex_mem.ctrl.wb_load
                     && ex_mem.ctrl.br_kind == BR_NONE))
        else begin
            $error("data write without a store in EX/MEM");
            fail_count++;
        end

endmodule

/* sim/la32_checker.sv */
`timescale 1ns/10ps

module la32_checker import la32_isa_pkg::*; (
    input logic      clk,
    input logic      rstn,
    input word_t     wb_pc,
    input logic      wb_we,
    input reg_addr_t wb_dest,
    input word_t     wb_data
);

    typedef struct packed {
        word_t     pc;
        logic      we;
        reg_addr_t dest;
        word_t     data;
        logic      loop;
    } commit_t;

    word_t   ref_regs [32];
    word_t   ref_dmem [64];
    word_t   ref_pc;
    commit_t exp_c;
    logic    active;
    logic    test_done;
    int      test_id;
    int      test_errs;
    int      test_writes;
    int      err_count;
    int      write_count;

    initial begin
        active      = 1'b0;
        test_done   = 1'b0;
        err_count   = 0;
        write_count = 0;
    end

    // one instruction of the architectural model
    function automatic commit_t ref_step();
        commit_t     c;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic [31:0] si12;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic [27:0] offs26;
        logic        wr;
        w       = tb_la32.imem[ref_pc[9:2]];
        a       = ref_regs[w[9:5]];
        b       = ref_regs[w[14:10]];
        d       = ref_regs[w[4:0]];
        si12    = {{20{w[21]}}, w[21:10]};
        res     = '0;
        wr      = 1'b0;
        next_pc = ref_pc + 32'd4;
        c       = '0;
        c.pc    = ref_pc;
        offs26  = {w[9:0], w[25:10], 2'b00};
        if (w == 32'h5000_0000) begin
            c.loop  = 1'b1;
            next_pc = ref_pc;
        end else if (w[31:15] == 17'h00020) begin
            res = a + b;
            wr  = 1'b1;
        end else if (w[31:15] == 17'h00022) begin
            res = a - b;
            wr  = 1'b1;
        end else if (w[31:15] == 17'h00029) begin
            res = a & b;
            wr  = 1'b1;
        end else if (w[31:15] == 17'h0002a) begin
            res = a | b;
            wr  = 1'b1;
        end else if (w[31:15] == 17'h0002b) begin
            res = a ^ b;
            wr  = 1'b1;
        end else if (w[31:22] == 10'h00a) begin
            res = a + si12;
            wr  = 1'b1;
        end else if (w[31:22] == 10'h0a2) begin
            res = ref_dmem[5'(0) + 6'((a + si12) >> 2)];
            wr  = 1'b1;
        end else if (w[31:22] == 10'h0a6) begin
            ref_dmem[6'((a + si12) >> 2)] = d;
        end else if (w[31:25] == 7'h0a) begin
            res = {w[24:5], 12'h000};
            wr  = 1'b1;
        end else if (w[31:26] == 6'h16 && a == d) begin
            next_pc = ref_pc + {{14{w[25]}}, w[25:10], 2'b00};
        end else if (w[31:26] == 6'h17 && a != d) begin
            next_pc = ref_pc + {{14{w[25]}}, w[25:10], 2'b00};
        end else if (w[31:26] == 6'h14) begin
            next_pc = ref_pc + {{4{offs26[27]}}, offs26};
        end
        if (wr && w[4:0] != 5'd0) begin
            c.we              = 1'b1;
            c.dest            = w[4:0];
            c.data            = res;
            ref_regs[w[4:0]] = res;
        end
        ref_pc = next_pc;
        return c;
    endfunction

    // run the model up to its next register write or the final loop
    task automatic advance();
        int n;
        n = 0;
        exp_c = ref_step();
        while (!exp_c.we && !exp_c.loop && n < 300) begin
            exp_c = ref_step();
            n++;
        end
        if (exp_c.loop) begin
            test_done = 1'b1;
            $display("test %0d done: %0d writes checked, %0d errors",
                     test_id, test_writes, test_errs);
        end
    endtask

    task automatic begin_test(input int id);
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            ref_dmem[i] = '0;
        end
        ref_pc      = RESET_PC;
        test_id     = id;
        test_errs   = 0;
        test_writes = 0;
        test_done   = 1'b0;
        active      = 1'b1;
        advance();
    endtask

    task automatic count_error();
        test_errs++;
        err_count++;
    endtask

    always @(posedge clk) begin
        if (rstn && active && wb_we) begin
            if (test_done) begin
                $display("test %0d: register write after the program reached its end", test_id);
                count_error();
            end else begin
                test_writes++;
                write_count++;
                if (wb_pc !== exp_c.pc) begin
                    $display("Error: wb_pc = %h, expected %h", wb_pc, exp_c.pc);
                    count_error();
                end
                if (wb_dest !== exp_c.dest) begin
                    $display("Error: wb_dest = %h, expected %h", wb_dest, exp_c.dest);
                    count_error();
                end
                if (wb_data !== exp_c.data) begin
                    $display("Error: wb_data = %h, expected %h (pc %h)",
                             wb_data, exp_c.data, exp_c.pc);
                    count_error();
                end
                advance();
            end
        end
    end

endmodule

/* sim/tb_la32.sv */
`timescale 1ns/10ps

module tb_la32 import la32_isa_pkg::*; ();

    localparam int NUM_TESTS   = 5;
    localparam int MAX_INSTS   = 64;
    localparam int CYCLE_LIMIT = MAX_INSTS * 3 + 20;
    localparam int SEED        = 82;

    logic      clk;
    logic      rstn;
    waddr_t    imem_addr;
    word_t     imem_rdata;
    logic      dmem_we;
    waddr_t    dmem_addr;
    word_t     dmem_wdata;
    word_t     dmem_rdata;
    word_t     wb_pc;
    logic      wb_we;
    reg_addr_t wb_dest;
    word_t     wb_data;

    word_t imem [256];
    word_t dmem [64];
    int    pos;

    logic [16:0] ops3r [5] = '{17'h00020, 17'h00022, 17'h00029, 17'h0002a, 17'h0002b};

    la32_core i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .wb_pc      (wb_pc),
        .wb_we      (wb_we),
        .wb_dest    (wb_dest),
        .wb_data    (wb_data)
    );

    la32_checker i_check (
        .clk     (clk),
        .rstn    (rstn),
        .wb_pc   (wb_pc),
        .wb_we   (wb_we),
        .wb_dest (wb_dest),
        .wb_data (wb_data)
    );

    bind la32_core la32_asserts u_asserts (
        .clk      (clk),
        .rstn     (rstn),
        .wb_we    (wb_we),
        .stall    (stall),
        .flush    (flush),
        .fwd1_sel (fwd1_sel),
        .fwd2_sel (fwd2_sel),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .dmem_we  (dmem_we)
    );

    // both memories read combinationally
    assign imem_rdata = imem[imem_addr[7:0]];
    assign dmem_rdata = dmem[dmem_addr[5:0]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[5:0]] <= dmem_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t r3_word(input logic [16:0] op, input logic [4:0] rd,
                                      input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t ri12_word(input logic [9:0] op, input logic [4:0] rd,
                                        input logic [4:0] rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic word_t branch_word(input logic [5:0] op, input logic [4:0] rj,
                                          input logic [4:0] rd, input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic word_t jump_word(input logic [25:0] offs);
        return {6'h14, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [4:0] scratch_reg();
        return 5'(1 + $urandom % 7);
    endfunction

    function automatic logic [11:0] data_offset();
        return 12'(4 * ($urandom % 64));
    endfunction

    task automatic emit(input word_t w);
        imem[pos] = w;
        pos++;
    endtask

    task automatic addi(input logic [4:0] rd, input logic [4:0] rj, input logic [11:0] imm);
        emit(ri12_word(10'h00a, rd, rj, imm));
    endtask

    task automatic build_program(input int t);
        logic [4:0]  cur;
        logic [4:0]  prev;
        logic [4:0]  older;
        logic [4:0]  r;
        logic [11:0] a;
        int          k;
        pos = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 1; i < 8; i++) begin
            addi(5'(i), 5'd0, 12'($urandom));
        end
        case (t)
            0: begin
                prev  = 5'd7;
                older = 5'd6;
                // one operand one back, the other two back
                for (int i = 0; i < 24; i++) begin
                    cur = scratch_reg();
                    k   = $urandom % 6;
                    if (k == 5)
                        addi(cur, prev, 12'($urandom));
                    else if (i % 2 == 1)
                        emit(r3_word(ops3r[k], cur, prev, older));
                    else
                        emit(r3_word(ops3r[k], cur, older, prev));
                    older = prev;
                    prev  = cur;
                end
            end
            1: begin
                for (int i = 0; i < 8; i++) begin
                    r = scratch_reg();
                    emit({7'h0a, 20'($urandom), r});
                    addi(r, r, 12'($urandom));
                    addi(5'd0, r, 12'($urandom));
                    emit(r3_word(ops3r[0], scratch_reg(), 5'd0, r));
                end
            end
            2: begin
                for (int i = 0; i < 10; i++) begin
                    r = scratch_reg();
                    a = data_offset();
                    addi(r, 5'd0, 12'($urandom));
                    emit(ri12_word(10'h0a6, r, 5'd0, a));
                    r = scratch_reg();
                    emit(ri12_word(10'h0a2, r, 5'd0, a));
                    emit(r3_word(ops3r[$urandom % 5], scratch_reg(), r, r));
                end
            end
            3: begin
                addi(5'd1, 5'd0, 12'd5);
                addi(5'd2, 5'd0, 12'd5);
                addi(5'd3, 5'd0, 12'd9);
                // each taken branch skips two junk writes to r9 and r10
                emit(branch_word(6'h16, 5'd1, 5'd2, 16'd3));
                addi(5'd9, 5'd0, 12'h111);
                addi(5'd10, 5'd0, 12'h222);
                emit(branch_word(6'h17, 5'd1, 5'd2, 16'd2));
                addi(5'd4, 5'd0, 12'd1);
                emit(branch_word(6'h17, 5'd1, 5'd3, 16'd3));
                addi(5'd9, 5'd0, 12'h333);
                addi(5'd10, 5'd0, 12'h444);
                emit(branch_word(6'h16, 5'd1, 5'd3, 16'd2));
                addi(5'd5, 5'd0, 12'd2);
                emit(jump_word(26'd3));
                addi(5'd9, 5'd0, 12'h555);
                addi(5'd10, 5'd0, 12'h666);
                emit(r3_word(ops3r[0], 5'd6, 5'd4, 5'd5));
                emit(branch_word(6'h16, 5'd6, 5'd6, 16'd3));
                addi(5'd9, 5'd0, 12'h777);
                addi(5'd10, 5'd0, 12'h888);
                addi(5'd7, 5'd6, 12'd1);
            end
            default: begin
                for (int i = 0; i < 44; i++) begin
                    k = $urandom % 12;
                    if (k < 5)
                        emit(r3_word(ops3r[k], scratch_reg(), scratch_reg(), scratch_reg()));
                    else if (k == 5)
                        addi(scratch_reg(), scratch_reg(), 12'($urandom));
                    else if (k == 6)
                        emit({7'h0a, 20'($urandom), scratch_reg()});
                    else if (k == 7)
                        emit(ri12_word(10'h0a6, scratch_reg(), 5'd0, data_offset()));
                    else if (k == 8)
                        emit(ri12_word(10'h0a2, scratch_reg(), 5'd0, data_offset()));
                    else if (k == 9)
                        emit(branch_word(6'h16, scratch_reg(), scratch_reg(),
                                         16'(1 + $urandom % 3)));
                    else if (k == 10)
                        emit(branch_word(6'h17, scratch_reg(), scratch_reg(),
                                         16'(1 + $urandom % 3)));
                    else
                        emit(jump_word(26'(1 + $urandom % 3)));
                end
                for (int i = 0; i < 3; i++) begin
                    addi(scratch_reg(), scratch_reg(), 12'($urandom));
                end
            end
        endcase
        emit(jump_word(26'd0));
    endtask

    initial begin
        int   cycles;
        int   tests_run;
        logic hung;
        hung      = 1'b0;
        tests_run = 0;
        void'($urandom(SEED));
        rstn = 1'b0;
        for (int t = 0; t < NUM_TESTS && !hung; t++) begin
            build_program(t);
            for (int i = 0; i < 64; i++) begin
                dmem[i] = '0;
            end
            @(posedge clk);
            rstn <= 1'b0;
            repeat (4) @(posedge clk);
            i_check.begin_test(t);
            rstn <= 1'b1;
            cycles = 0;
            while (!i_check.test_done && cycles < CYCLE_LIMIT) begin
                @(posedge clk);
                cycles++;
            end
            tests_run++;
            if (!i_check.test_done) begin
                $display("test %0d hung: the program did not finish within %0d cycles",
                         t, CYCLE_LIMIT);
                hung = 1'b1;
            end
        end
        $display("%0d tests run, %0d writes checked, %0d errors, %0d assertion failures",
                 tests_run, i_check.write_count, i_check.err_count,
                 i_dut.u_asserts.fail_count);
        if (!hung && i_check.err_count == 0 && i_dut.u_asserts.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* vlog.f */
hw/la32_isa_pkg.sv
hw/pipe_pkg.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/la32_core.sv
sim/la32_asserts.sv
sim/la32_checker.sv
sim/tb_la32.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_la32 -f vlog.f -o sim_la32
./obj_dir/sim_la32 > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log || ! grep -qF "*** TEST PASSED ***" sim.log; then
    exit 1
fi
